//--- hw/isaPkg.sv
package isaPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;

    // Field positions in the instruction word
    localparam int opcodeLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;

    // Primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // Function codes under opSpecial
    typedef enum logic [5:0] {
        functAddu = 6'h21,
        functSubu = 6'h23
    } functT;

endpackage

//--- hw/pipePkg.sv
package pipePkg;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLoadUpper
    } aluOpT;

    typedef enum logic {
        srcAlu,
        srcMemory
    } regDataSrcT;

    typedef enum logic {
        dstRt,
        dstRd
    } regDstT;

    typedef enum logic {
        fwdDRegFile,
        fwdDAluM
    } fwdDecodeT;

    typedef enum logic [1:0] {
        fwdERegFile,
        fwdEAluM,
        fwdERegDataW
    } fwdExecT;

    // Tuse and Tnew in cycles
    localparam int hazardTimeWidth = 2;
    localparam logic [hazardTimeWidth-1:0] tuseBranch = 2'd0;
    localparam logic [hazardTimeWidth-1:0] tuseOther = 2'd1;
    localparam logic [hazardTimeWidth-1:0] tnewAluE = 2'd1;
    localparam logic [hazardTimeWidth-1:0] tnewLoadE = 2'd2;
    localparam logic [hazardTimeWidth-1:0] tnewLoadM = 2'd1;

    localparam logic [isaPkg::dataWidth-1:0] resetPc = 32'h0000_3000;

endpackage

//--- hw/regFile.sv
`timescale 1ns/1ps
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write bypass
    assign readDataA = (readAddrA == 5'd0) ? '0 :
                       (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 :
                       (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ps
module fetchUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic                          branchTaken,
    input  logic [isaPkg::immWidth-1:0]   branchOffset,
    input  logic [isaPkg::dataWidth-1:0]  instData,
    output logic [isaPkg::dataWidth-1:0]  instAddr,
    output logic [isaPkg::dataWidth-1:0]  instD,
    output logic [isaPkg::dataWidth-1:0]  pcD
);
    logic [isaPkg::dataWidth-1:0] pc;
    logic [isaPkg::dataWidth-1:0] branchTarget;

    // pc holds the delay slot while the branch sits in decode
    assign branchTarget = pc + 32'd4 +
        {{(isaPkg::dataWidth - isaPkg::immWidth - 2){branchOffset[isaPkg::immWidth-1]}},
         branchOffset, 2'b00};
    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= pipePkg::resetPc;
            instD <= '0;
        end else if (!stall) begin
            pc <= branchTaken ? branchTarget : pc + 32'd4;
            instD <= instData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pc;
        end
    end

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/1ps
module controlUnit (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [isaPkg::dataWidth-1:0]     instD,
    input  logic                             branchEqual,
    output logic                             stall,
    output logic                             branchTaken,
    output pipePkg::aluOpT                   aluOpE,
    output logic                             aluSrcImmE,
    output logic                             signImmD,
    output logic [isaPkg::regAddrWidth-1:0]  destE,
    output pipePkg::fwdDecodeT               fwdRsD,
    output pipePkg::fwdDecodeT               fwdRtD,
    output pipePkg::fwdExecT                 fwdRsE,
    output pipePkg::fwdExecT                 fwdRtE,
    output logic                             memWriteE,
    output logic                             regWriteE,
    output pipePkg::regDataSrcT              regDataSrcE,
    output logic [isaPkg::regAddrWidth-1:0]  destM,
    output logic [isaPkg::regAddrWidth-1:0]  destW,
    output logic                             regWriteW
);
    logic [isaPkg::regAddrWidth-1:0] rsD, rtD, rdD, destD, rsE, rtE;
    logic [pipePkg::hazardTimeWidth-1:0] tuseD, tnewD, tnewE, tnewM;
    logic regWriteD, memWriteD, loadD, beqD, useRsD, useRtD, aluSrcImmD;
    logic loadE, loadM, regWriteM, stallRs, stallRt;
    pipePkg::aluOpT aluOpD;
    pipePkg::regDataSrcT regDataSrcD;
    pipePkg::regDstT regDstD;

    assign rsD = instD[isaPkg::rsLsb +: isaPkg::regAddrWidth];
    assign rtD = instD[isaPkg::rtLsb +: isaPkg::regAddrWidth];
    assign rdD = instD[isaPkg::rdLsb +: isaPkg::regAddrWidth];

    always_comb begin
        {regWriteD, memWriteD, loadD, beqD, useRsD, useRtD, aluSrcImmD, signImmD} = '0;
        aluOpD = pipePkg::aluAdd;
        regDataSrcD = pipePkg::srcAlu;
        regDstD = pipePkg::dstRt;
        tuseD = pipePkg::tuseOther;
        tnewD = '0;
        case (instD[isaPkg::opcodeLsb +: $bits(isaPkg::opcodeT)])
            isaPkg::opSpecial: begin
                if (instD[5:0] == isaPkg::functAddu || instD[5:0] == isaPkg::functSubu) begin
                    {regWriteD, useRsD, useRtD} = 3'b111;
                    regDstD = pipePkg::dstRd;
                    tnewD = pipePkg::tnewAluE;
                    aluOpD = (instD[5:0] == isaPkg::functSubu) ? pipePkg::aluSub
                                                               : pipePkg::aluAdd;
                end
            end
            isaPkg::opOri: begin
                {regWriteD, useRsD, aluSrcImmD} = 3'b111;
                aluOpD = pipePkg::aluOr;
                tnewD = pipePkg::tnewAluE;
            end
            isaPkg::opLui: begin
                {regWriteD, aluSrcImmD} = 2'b11;
                aluOpD = pipePkg::aluLoadUpper;
                tnewD = pipePkg::tnewAluE;
            end
            isaPkg::opLw: begin
                {regWriteD, loadD, useRsD, aluSrcImmD, signImmD} = 5'b11111;
                regDataSrcD = pipePkg::srcMemory;
                tnewD = pipePkg::tnewLoadE;
            end
            isaPkg::opSw: {memWriteD, useRsD, useRtD, aluSrcImmD, signImmD} = 5'b11111;
            isaPkg::opBeq: begin
                {beqD, useRsD, useRtD, signImmD} = 4'b1111;
                tuseD = pipePkg::tuseBranch;
            end
            default: ;
        endcase
    end

    // Zero destination means no write
    assign destD = !regWriteD ? '0 : (regDstD == pipePkg::dstRd) ? rdD : rtD;

    // Tnew of a writer in write-back is always zero
    assign stallRs = useRsD && rsD != '0 &&
                     ((rsD == destE && tnewE > tuseD) || (rsD == destM && tnewM > tuseD));
    assign stallRt = useRtD && rtD != '0 &&
                     ((rtD == destE && tnewE > tuseD) || (rtD == destM && tnewM > tuseD));
    assign stall = stallRs || stallRt;
    assign branchTaken = beqD && branchEqual && !stall;

    assign fwdRsD = (rsD != '0 && rsD == destM && !loadM) ? pipePkg::fwdDAluM
                                                           : pipePkg::fwdDRegFile;
    assign fwdRtD = (rtD != '0 && rtD == destM && !loadM) ? pipePkg::fwdDAluM
                                                           : pipePkg::fwdDRegFile;
    assign fwdRsE = (rsE != '0 && rsE == destM && !loadM) ? pipePkg::fwdEAluM :
                    (rsE != '0 && rsE == destW) ? pipePkg::fwdERegDataW : pipePkg::fwdERegFile;
    assign fwdRtE = (rtE != '0 && rtE == destM && !loadM) ? pipePkg::fwdEAluM :
                    (rtE != '0 && rtE == destW) ? pipePkg::fwdERegDataW : pipePkg::fwdERegFile;

    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            // bubble into execute
            {aluSrcImmE, memWriteE, regWriteE, loadE} <= '0;
            {destE, rsE, rtE, tnewE} <= '0;
            aluOpE <= pipePkg::aluAdd;
            regDataSrcE <= pipePkg::srcAlu;
        end else begin
            aluOpE <= aluOpD;
            aluSrcImmE <= aluSrcImmD;
            memWriteE <= memWriteD;
            regWriteE <= destD != '0;
            regDataSrcE <= regDataSrcD;
            loadE <= loadD;
            destE <= destD;
            rsE <= rsD;
            rtE <= rtD;
            tnewE <= tnewD;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            {destM, destW, tnewM, loadM, regWriteM, regWriteW} <= '0;
        end else begin
            destM <= destE;
            loadM <= loadE;
            tnewM <= loadE ? pipePkg::tnewLoadM : '0;
            regWriteM <= regWriteE;
            destW <= destM;
            regWriteW <= regWriteM;
        end
    end

endmodule

//--- hw/executeUnit.sv
`timescale 1ns/1ps
module executeUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic [isaPkg::dataWidth-1:0]  instD,
    input  logic [isaPkg::dataWidth-1:0]  pcD,
    input  logic [isaPkg::dataWidth-1:0]  rsDataD,
    input  logic [isaPkg::dataWidth-1:0]  rtDataD,
    input  pipePkg::fwdDecodeT            fwdRsD,
    input  pipePkg::fwdDecodeT            fwdRtD,
    input  pipePkg::fwdExecT              fwdRsE,
    input  pipePkg::fwdExecT              fwdRtE,
    input  pipePkg::aluOpT                aluOpE,
    input  logic                          aluSrcImmE,
    input  logic                          signImmD,
    input  logic [isaPkg::dataWidth-1:0]  aluResultM,
    input  logic [isaPkg::dataWidth-1:0]  regDataW,
    output logic                          branchEqual,
    output logic [isaPkg::dataWidth-1:0]  aluResultE,
    output logic [isaPkg::dataWidth-1:0]  storeDataE,
    output logic [isaPkg::dataWidth-1:0]  pcE
);
    logic [isaPkg::dataWidth-1:0] rsFwdD, rtFwdD, immD;
    logic [isaPkg::dataWidth-1:0] rsDataE, rtDataE, immE, srcA, srcB;

    assign rsFwdD = (fwdRsD == pipePkg::fwdDAluM) ? aluResultM : rsDataD;
    assign rtFwdD = (fwdRtD == pipePkg::fwdDAluM) ? aluResultM : rtDataD;
    assign branchEqual = rsFwdD == rtFwdD;

    assign immD = {{(isaPkg::dataWidth - isaPkg::immWidth){signImmD & instD[isaPkg::immWidth-1]}},
                   instD[isaPkg::immWidth-1:0]};

    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            {rsDataE, rtDataE, immE, pcE} <= '0;
        end else begin
            rsDataE <= rsFwdD;
            rtDataE <= rtFwdD;
            immE <= immD;
            pcE <= pcD;
        end
    end

    assign srcA = (fwdRsE == pipePkg::fwdEAluM) ? aluResultM :
                  (fwdRsE == pipePkg::fwdERegDataW) ? regDataW : rsDataE;
    assign storeDataE = (fwdRtE == pipePkg::fwdEAluM) ? aluResultM :
                        (fwdRtE == pipePkg::fwdERegDataW) ? regDataW : rtDataE;
    assign srcB = aluSrcImmE ? immE : storeDataE;

    always_comb begin
        case (aluOpE)
            pipePkg::aluSub: aluResultE = srcA - srcB;
            pipePkg::aluOr: aluResultE = srcA | srcB;
            pipePkg::aluLoadUpper: aluResultE = {srcB[15:0], 16'h0000};
            default: aluResultE = srcA + srcB;
        endcase
    end

endmodule

//--- hw/memAccess.sv
`timescale 1ns/1ps
module memAccess (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [isaPkg::dataWidth-1:0]     aluResultE,
    input  logic [isaPkg::dataWidth-1:0]     storeDataE,
    input  logic [isaPkg::dataWidth-1:0]     pcE,
    input  logic                             memWriteE,
    input  logic                             regWriteE,
    input  pipePkg::regDataSrcT              regDataSrcE,
    input  logic [isaPkg::regAddrWidth-1:0]  destE,
    input  logic [isaPkg::dataWidth-1:0]     dataRdata,
    output logic [isaPkg::dataWidth-1:0]     dataAddr,
    output logic [isaPkg::dataWidth-1:0]     dataWdata,
    output logic [3:0]                       dataByteen,
    output logic [isaPkg::dataWidth-1:0]     aluResultM,
    output logic                             regWriteW,
    output logic [isaPkg::regAddrWidth-1:0]  destW,
    output logic [isaPkg::dataWidth-1:0]     regDataW,
    output logic [isaPkg::dataWidth-1:0]     pcW
);
    logic [isaPkg::dataWidth-1:0] storeDataM, pcM, aluResultW, memDataW;
    logic [isaPkg::regAddrWidth-1:0] destM;
    logic memWriteM, regWriteM;
    pipePkg::regDataSrcT regDataSrcM, regDataSrcW;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            {memWriteM, regWriteM, regWriteW, destM, destW} <= '0;
            regDataSrcM <= pipePkg::srcAlu;
            regDataSrcW <= pipePkg::srcAlu;
        end else begin
            memWriteM <= memWriteE;
            regWriteM <= regWriteE;
            destM <= destE;
            regDataSrcM <= regDataSrcE;
            regWriteW <= regWriteM;
            destW <= destM;
            regDataSrcW <= regDataSrcM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        storeDataM <= storeDataE;
        pcM <= pcE;
        aluResultW <= aluResultM;
        memDataW <= dataRdata;
        pcW <= pcM;
    end

    // Word stores only
    assign dataAddr = aluResultM;
    assign dataWdata = storeDataM;
    assign dataByteen = {4{memWriteM}};

    assign regDataW = (regDataSrcW == pipePkg::srcMemory) ? memDataW : aluResultW;

endmodule

//--- hw/cpuTop.sv
`timescale 1ns/1ps
module cpuTop (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [isaPkg::dataWidth-1:0]     instData,
    input  logic [isaPkg::dataWidth-1:0]     dataRdata,
    output logic [isaPkg::dataWidth-1:0]     instAddr,
    output logic [isaPkg::dataWidth-1:0]     dataAddr,
    output logic [isaPkg::dataWidth-1:0]     dataWdata,
    output logic [3:0]                       dataByteen,
    output logic                             grfWe,
    output logic [isaPkg::regAddrWidth-1:0]  grfAddr,
    output logic [isaPkg::dataWidth-1:0]     grfWdata,
    output logic [isaPkg::dataWidth-1:0]     wInstAddr
);
    logic stall;
    logic branchTaken;
    logic branchEqual;
    logic aluSrcImmE;
    logic signImmD;
    logic memWriteE;
    logic regWriteE;
    logic ctrlRegWriteW;
    pipePkg::aluOpT aluOpE;
    pipePkg::regDataSrcT regDataSrcE;
    pipePkg::fwdDecodeT fwdRsD;
    pipePkg::fwdDecodeT fwdRtD;
    pipePkg::fwdExecT fwdRsE;
    pipePkg::fwdExecT fwdRtE;
    logic [isaPkg::regAddrWidth-1:0] destE;
    logic [isaPkg::regAddrWidth-1:0] ctrlDestW;
    logic [isaPkg::dataWidth-1:0] instD;
    logic [isaPkg::dataWidth-1:0] pcD;
    logic [isaPkg::dataWidth-1:0] rsDataD;
    logic [isaPkg::dataWidth-1:0] rtDataD;
    logic [isaPkg::dataWidth-1:0] aluResultE;
    logic [isaPkg::dataWidth-1:0] storeDataE;
    logic [isaPkg::dataWidth-1:0] pcE;
    logic [isaPkg::dataWidth-1:0] aluResultM;

    controlUnit controlUnit_i (
        .clk(clk), .rstN(rstN), .instD(instD), .branchEqual(branchEqual),
        .stall(stall), .branchTaken(branchTaken), .aluOpE(aluOpE),
        .aluSrcImmE(aluSrcImmE), .signImmD(signImmD), .destE(destE),
        .fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE),
        .memWriteE(memWriteE), .regWriteE(regWriteE), .regDataSrcE(regDataSrcE),
        .destM(), .destW(ctrlDestW), .regWriteW(ctrlRegWriteW)
    );

    fetchUnit fetchUnit_i (
        .clk(clk), .rstN(rstN), .stall(stall), .branchTaken(branchTaken),
        .branchOffset(instD[isaPkg::immWidth-1:0]), .instData(instData),
        .instAddr(instAddr), .instD(instD), .pcD(pcD)
    );

    regFile regFile_i (
        .clk(clk), .rstN(rstN),
        .readAddrA(instD[isaPkg::rsLsb +: isaPkg::regAddrWidth]),
        .readAddrB(instD[isaPkg::rtLsb +: isaPkg::regAddrWidth]),
        .writeEn(ctrlRegWriteW), .writeAddr(ctrlDestW), .writeData(grfWdata),
        .readDataA(rsDataD), .readDataB(rtDataD)
    );

    executeUnit executeUnit_i (
        .clk(clk), .rstN(rstN), .stall(stall), .instD(instD), .pcD(pcD),
        .rsDataD(rsDataD), .rtDataD(rtDataD), .fwdRsD(fwdRsD), .fwdRtD(fwdRtD),
        .fwdRsE(fwdRsE), .fwdRtE(fwdRtE), .aluOpE(aluOpE), .aluSrcImmE(aluSrcImmE),
        .signImmD(signImmD), .aluResultM(aluResultM), .regDataW(grfWdata),
        .branchEqual(branchEqual), .aluResultE(aluResultE),
        .storeDataE(storeDataE), .pcE(pcE)
    );

    memAccess memAccess_i (
        .clk(clk), .rstN(rstN), .aluResultE(aluResultE), .storeDataE(storeDataE),
        .pcE(pcE), .memWriteE(memWriteE), .regWriteE(regWriteE),
        .regDataSrcE(regDataSrcE), .destE(destE), .dataRdata(dataRdata),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataByteen(dataByteen),
        .aluResultM(aluResultM), .regWriteW(grfWe), .destW(grfAddr),
        .regDataW(grfWdata), .pcW(wInstAddr)
    );

endmodule

//--- verification/cpuTop_checker.sv
`timescale 1ns/1ps
module cpuTop_checker (
    input logic                             clk,
    input logic                             rstN,
    input logic                             grfWe,
    input logic [isaPkg::regAddrWidth-1:0]  grfAddr,
    input logic [3:0]                       dataByteen,
    input logic [isaPkg::dataWidth-1:0]     instAddr
);

    // Register 0 never shows up on the write-back port
    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        grfWe |-> grfAddr != '0)
        else $error("write-back event targets register 0");

    // Word stores only
    wordEnables: assert property (@(posedge clk) disable iff (!rstN)
        dataByteen == 4'h0 || dataByteen == 4'hf)
        else $error("partial byte enables on the data port");

    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        instAddr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    // First cycle out of reset is quiet
    resetQuiet: assert property (@(posedge clk)
        $rose(rstN) |-> !grfWe && dataByteen == 4'h0)
        else $error("write-back or store active right after reset");

endmodule

bind cpuTop cpuTop_checker checker_i (
    .clk(clk),
    .rstN(rstN),
    .grfWe(grfWe),
    .grfAddr(grfAddr),
    .dataByteen(dataByteen),
    .instAddr(instAddr)
);

//--- verification/cpuTb.sv
`timescale 1ns/1ps
module cpuTb;
    localparam int numEntries = 12;
    localparam int imemWords = 32;
    localparam int dmemWords = 1024;
    localparam int timeoutCycles = 200;

    // Expected write-back sequence as register, value and instruction address
    localparam logic [4:0] expReg [numEntries] = '{
        5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd13, 5'd14
    };
    localparam logic [31:0] expValue [numEntries] = '{
        32'h0000_1234, 32'habcd_0000, 32'habcd_1234, 32'habcd_0000,
        32'h579a_1234, 32'h0000_0010, 32'h579a_1234, 32'h579a_2468,
        32'h0000_1234, 32'h0000_0011, 32'h0000_0044, 32'h0000_0044
    };
    localparam logic [31:0] expPc [numEntries] = '{
        32'h3000, 32'h3004, 32'h300c, 32'h3010, 32'h3014, 32'h3018,
        32'h3020, 32'h3024, 32'h3028, 32'h3030, 32'h3040, 32'h3048
    };
    localparam logic [31:0] storeAddr = 32'h0000_0014;
    localparam logic [31:0] storeValue = 32'h579a_1234;

    logic clk;
    logic rstN;
    logic [31:0] instData, dataRdata, instAddr, dataAddr, dataWdata;
    logic [31:0] grfWdata, wInstAddr, instOffset;
    logic [3:0] dataByteen;
    logic grfWe;
    logic [4:0] grfAddr;
    logic [31:0] imem [imemWords];
    logic [31:0] dmem [dmemWords];
    int entryIdx, storeCount, valueErrors, otherErrors, cycles;

    function automatic logic [31:0] iType(isaPkg::opcodeT op, logic [4:0] rs,
                                          logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          isaPkg::functT fn);
        return {isaPkg::opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    cpuTop cpuTop_i (
        .clk(clk), .rstN(rstN), .instData(instData), .dataRdata(dataRdata),
        .instAddr(instAddr), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataByteen(dataByteen), .grfWe(grfWe), .grfAddr(grfAddr),
        .grfWdata(grfWdata), .wInstAddr(wInstAddr)
    );

    always #4 clk = ~clk;

    // Both memories answer in the same cycle
    assign instOffset = instAddr - pipePkg::resetPc;
    assign instData = (rstN && instOffset < imemWords * 4) ? imem[instOffset[6:2]] : '0;
    assign dataRdata = rstN ? dmem[dataAddr[11:2]] : '0;

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dataByteen[b]) begin
                dmem[dataAddr[11:2]][8*b +: 8] <= dataWdata[8*b +: 8];
            end
        end
    end

    task automatic loadMemories();
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = 32'ha5a5_0000 ^ (i << 2);
        end
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = '0;
        end
        imem[0] = iType(isaPkg::opOri, 5'd0, 5'd1, 16'h1234);
        imem[1] = iType(isaPkg::opLui, 5'd0, 5'd2, 16'habcd);
        // Word 2 stays a nop
        imem[3] = rType(5'd1, 5'd2, 5'd3, isaPkg::functAddu);
        imem[4] = rType(5'd3, 5'd1, 5'd4, isaPkg::functSubu);
        imem[5] = rType(5'd4, 5'd3, 5'd5, isaPkg::functAddu);
        imem[6] = iType(isaPkg::opOri, 5'd0, 5'd6, 16'h0010);
        imem[7] = iType(isaPkg::opSw, 5'd6, 5'd5, 16'h0004);
        imem[8] = iType(isaPkg::opLw, 5'd6, 5'd7, 16'h0004);
        imem[9] = rType(5'd7, 5'd1, 5'd8, isaPkg::functAddu);
        // r9 only matches r1 through the forwarded value
        imem[10] = iType(isaPkg::opOri, 5'd0, 5'd9, 16'h1234);
        // Taken to 0x303c with the delay slot at 0x3030
        imem[11] = iType(isaPkg::opBeq, 5'd9, 5'd1, 16'h0002);
        imem[12] = iType(isaPkg::opOri, 5'd0, 5'd10, 16'h0011);
        imem[13] = iType(isaPkg::opOri, 5'd0, 5'd11, 16'h0022);
        imem[14] = iType(isaPkg::opOri, 5'd0, 5'd12, 16'h0033);
        imem[15] = iType(isaPkg::opBeq, 5'd1, 5'd2, 16'h0003);
        imem[16] = iType(isaPkg::opOri, 5'd0, 5'd13, 16'h0044);
        imem[17] = iType(isaPkg::opOri, 5'd0, 5'd0, 16'h0055);
        imem[18] = rType(5'd0, 5'd13, 5'd14, isaPkg::functAddu);
    endtask

    // Outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (rstN && grfWe) begin
            if (entryIdx >= numEntries) begin
                otherErrors++;
                $display("Unexpected write-back to register %0d from %h at %0t",
                         grfAddr, wInstAddr, $time);
            end else begin
                assert (grfAddr == expReg[entryIdx]) else begin
                    valueErrors++;
                    $display("Fail at %0t: grfAddr expected %0d got %0d",
                             $time, expReg[entryIdx], grfAddr);
                end
                assert (grfWdata == expValue[entryIdx]) else begin
                    valueErrors++;
                    $display("Fail at %0t: grfWdata expected %h got %h",
                             $time, expValue[entryIdx], grfWdata);
                end
                assert (wInstAddr == expPc[entryIdx]) else begin
                    valueErrors++;
                    $display("Fail at %0t: wInstAddr expected %h got %h",
                             $time, expPc[entryIdx], wInstAddr);
                end
                entryIdx++;
            end
        end
        if (rstN && dataByteen != 4'h0) begin
            storeCount++;
            assert (dataByteen == 4'hf) else begin
                valueErrors++;
                $display("Fail at %0t: dataByteen expected %h got %h",
                         $time, 4'hf, dataByteen);
            end
            assert (dataAddr == storeAddr) else begin
                valueErrors++;
                $display("Fail at %0t: dataAddr expected %h got %h", $time, storeAddr, dataAddr);
            end
            assert (dataWdata == storeValue) else begin
                valueErrors++;
                $display("Fail at %0t: dataWdata expected %h got %h",
                         $time, storeValue, dataWdata);
            end
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        entryIdx = 0;
        storeCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        cycles = 0;
        loadMemories();
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        while (entryIdx < numEntries && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (entryIdx < numEntries) begin
            otherErrors++;
            $display("Timeout: only %0d of %0d write-backs arrived within %0d cycles",
                     entryIdx, numEntries, timeoutCycles);
        end
        // Give stray writes from skipped instructions time to appear
        repeat (10) @(posedge clk);
        if (storeCount != 1) begin
            otherErrors++;
            $display("Expected exactly one store on the data port but saw %0d", storeCount);
        end
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/regFile.sv
hw/fetchUnit.sv
hw/controlUnit.sv
hw/executeUnit.sv
hw/memAccess.sv
hw/cpuTop.sv
verification/cpuTop_checker.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -j 0
PASS_MSG ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the cpuTop testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
